// ==== verilog/execUnit_config.svh ====
////////////////////
// Execution stage sizing
// Queue depths, credit counts and datapath widths
////////////////////
`ifndef EXEC_UNIT_CONFIG_SVH
`define EXEC_UNIT_CONFIG_SVH

// Operand and result width
`define EXEC_DATA_WIDTH 32

// Tag carried from command to write-back
`define EXEC_TAG_WIDTH 6

// Memory word address
`define EXEC_ADDR_WIDTH 8

// Command queue entries, also the upstream credit after reset
`define EXEC_COMMAND_DEPTH 4

// Write-back credit granted after reset
`define EXEC_WB_CREDITS 4

// Entries in each write-back queue
`define EXEC_RESULT_DEPTH 4

`endif

// ==== verilog/execPkg.sv ====
////////////////////
// Execution stage types
// Command kinds, ALU operations and queue payloads
////////////////////
`include "execUnit_config.svh"

package execPkg;

	////////////////////
	// Encodings
	////////////////////
	typedef enum logic [1:0] {
		kindAlu,
		kindMove,
		kindLoad,
		kindStore
	} commandKind_t;

	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl,				// Shift by low 5 bits of src2
		opShr,				// Logical shift right
		opSlt				// Signed compare
	} aluOp_t;

	typedef enum logic [1:0] {
		sourceAlu,
		sourceMove,
		sourceLoad
	} wbSource_t;

	////////////////////
	// Queue payloads
	////////////////////
	typedef struct packed {
		commandKind_t					kind;
		aluOp_t							aluOp;
		logic [`EXEC_TAG_WIDTH-1:0]		tag;
		logic [`EXEC_DATA_WIDTH-1:0]	src1;
		logic [`EXEC_DATA_WIDTH-1:0]	src2;
	} command_t;

	typedef struct packed {
		logic [`EXEC_TAG_WIDTH-1:0]		tag;
		logic [`EXEC_DATA_WIDTH-1:0]	data;
		wbSource_t						source;
	} wbEntry_t;

endpackage

// ==== verilog/ringBuffer.sv ====
////////////////////
// Circular FIFO for any payload type
////////////////////
module ringBuffer #(
	parameter type TYPE = logic [7:0],
	parameter int DEPTH = 4
)(
	input  logic							clock,
	input  logic							reset,
	input  logic							write,		// Push writeData
	input  logic							read,		// Pop head
	input  TYPE								writeData,
	output TYPE								readData,	// Head entry
	output logic							full,
	output logic							empty,
	output logic [$clog2(DEPTH+1)-1:0]		count
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	TYPE					storage [DEPTH];
	logic [PTR_WIDTH-1:0]	writePtr;
	logic [PTR_WIDTH-1:0]	readPtr;
	logic					doWrite;
	logic					doRead;

	// Wraps without needing a power-of-two depth
	function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full		= (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty	= (count == '0);
	assign doRead	= read && !empty;
	assign doWrite	= write && (!full || doRead);	// Full is fine when the head leaves too
	assign readData	= storage[readPtr];

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr	<= '0;
			readPtr		<= '0;
			count		<= '0;
		end else begin
			if (doWrite) begin
				writePtr	<= nextPtr(writePtr);
			end
			if (doRead) begin
				readPtr		<= nextPtr(readPtr);
			end
			if (doWrite && !doRead) begin
				count	<= count + 1'b1;
			end else if (doRead && !doWrite) begin
				count	<= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			storage[writePtr]	<= writeData;
		end
	end

endmodule

// ==== verilog/commandDecode.sv ====
////////////////////
// Command input side
// Queues commands, returns credits, dispatches to a path
////////////////////
`include "execUnit_config.svh"

module commandDecode (
	input  logic							clock,
	input  logic							reset,
	input  logic							commandValid,
	input  execPkg::commandKind_t			commandKind,
	input  execPkg::aluOp_t					commandAluOp,
	input  logic [`EXEC_TAG_WIDTH-1:0]		commandTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		commandSrc1,
	input  logic [`EXEC_DATA_WIDTH-1:0]		commandSrc2,
	output logic							commandCredit,
	input  logic							aluReady,
	input  logic							moveReady,
	input  logic							lsuReady,
	output logic							aluIssue,
	output logic							moveIssue,
	output logic							lsuIssue,
	output execPkg::aluOp_t					issueAluOp,
	output logic							issueIsStore,
	output logic [`EXEC_TAG_WIDTH-1:0]		issueTag,
	output logic [`EXEC_DATA_WIDTH-1:0]		issueSrc1,
	output logic [`EXEC_DATA_WIDTH-1:0]		issueSrc2
);

	execPkg::command_t	incoming;
	execPkg::command_t	head;
	logic				queueEmpty;
	logic				pathReady;
	logic				dispatch;

	assign incoming = '{
		kind:	commandKind,
		aluOp:	commandAluOp,
		tag:	commandTag,
		src1:	commandSrc1,
		src2:	commandSrc2
	};

	ringBuffer #(
		.TYPE(execPkg::command_t),
		.DEPTH(`EXEC_COMMAND_DEPTH)
	) commandQueue_i (
		.clock(clock),
		.reset(reset),
		.write(commandValid),				// Credits keep this from overflowing
		.read(dispatch),
		.writeData(incoming),
		.readData(head),
		.full(),
		.empty(queueEmpty),
		.count()
	);

	////////////////////
	// Dispatch
	////////////////////
	always_comb begin
		case (head.kind)
			execPkg::kindAlu:	pathReady = aluReady;
			execPkg::kindMove:	pathReady = moveReady;
			default:			pathReady = lsuReady;	// Loads and stores
		endcase
	end

	assign dispatch		= !queueEmpty && pathReady;
	assign aluIssue		= dispatch && (head.kind == execPkg::kindAlu);
	assign moveIssue	= dispatch && (head.kind == execPkg::kindMove);
	assign lsuIssue		= dispatch && (head.kind == execPkg::kindLoad ||
						  head.kind == execPkg::kindStore);

	assign issueAluOp	= head.aluOp;
	assign issueIsStore	= (head.kind == execPkg::kindStore);
	assign issueTag		= head.tag;
	assign issueSrc1	= head.src1;
	assign issueSrc2	= head.src2;

	// One credit back per popped entry
	always_ff @(posedge clock) begin
		if (reset) begin
			commandCredit	<= 1'b0;
		end else begin
			commandCredit	<= dispatch;
		end
	end

endmodule

// ==== verilog/scalarAlu.sv ====
////////////////////
// Two-stage integer ALU with stall
////////////////////
`include "execUnit_config.svh"

module scalarAlu (
	input  logic							clock,
	input  logic							reset,
	input  logic							aluIssue,
	input  execPkg::aluOp_t					issueAluOp,
	input  logic [`EXEC_TAG_WIDTH-1:0]		issueTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		issueSrc1,
	input  logic [`EXEC_DATA_WIDTH-1:0]		issueSrc2,
	output logic							aluReady,
	input  logic							aluQueueFull,
	output logic							aluResultValid,
	output logic [`EXEC_TAG_WIDTH-1:0]		aluResultTag,
	output logic [`EXEC_DATA_WIDTH-1:0]		aluResultData
);

	logic							stage1Valid;
	execPkg::aluOp_t				stage1Op;
	logic [`EXEC_TAG_WIDTH-1:0]		stage1Tag;
	logic [`EXEC_DATA_WIDTH-1:0]	stage1Src1;
	logic [`EXEC_DATA_WIDTH-1:0]	stage1Src2;
	logic							stage2Valid;
	logic [`EXEC_TAG_WIDTH-1:0]		stage2Tag;
	logic [`EXEC_DATA_WIDTH-1:0]	stage2Data;
	logic [`EXEC_DATA_WIDTH-1:0]	result;
	logic							stall;

	assign stall		= stage2Valid && aluQueueFull;	// Result cannot leave
	assign aluReady		= !stall;

	always_comb begin
		result = '0;
		case (stage1Op)
			execPkg::opAdd:	result = stage1Src1 + stage1Src2;
			execPkg::opSub:	result = stage1Src1 - stage1Src2;
			execPkg::opAnd:	result = stage1Src1 & stage1Src2;
			execPkg::opOr:	result = stage1Src1 | stage1Src2;
			execPkg::opXor:	result = stage1Src1 ^ stage1Src2;
			execPkg::opShl:	result = stage1Src1 << stage1Src2[4:0];
			execPkg::opShr:	result = stage1Src1 >> stage1Src2[4:0];
			default:		result[0] = $signed(stage1Src1) < $signed(stage1Src2);
		endcase
	end

	////////////////////
	// Pipeline control
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			stage1Valid	<= 1'b0;
			stage2Valid	<= 1'b0;
		end else if (!stall) begin
			stage1Valid	<= aluIssue;
			stage2Valid	<= stage1Valid;
		end
	end

	// Operands and result
	always_ff @(posedge clock) begin
		if (!stall) begin
			stage1Op	<= issueAluOp;
			stage1Tag	<= issueTag;
			stage1Src1	<= issueSrc1;
			stage1Src2	<= issueSrc2;
			stage2Tag	<= stage1Tag;
			stage2Data	<= result;
		end
	end

	assign aluResultValid	= stage2Valid;
	assign aluResultTag		= stage2Tag;
	assign aluResultData	= stage2Data;

endmodule

// ==== verilog/loadStoreUnit.sv ====
////////////////////
// Load/store sequencer
// One outstanding memory access at a time
////////////////////
`include "execUnit_config.svh"

module loadStoreUnit (
	input  logic							clock,
	input  logic							reset,
	input  logic							lsuIssue,
	input  logic							issueIsStore,
	input  logic [`EXEC_TAG_WIDTH-1:0]		issueTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		issueSrc1,
	input  logic [`EXEC_DATA_WIDTH-1:0]		issueSrc2,
	output logic							lsuReady,
	output logic							memReq,
	output logic							memWrite,
	output logic [`EXEC_ADDR_WIDTH-1:0]		memAddr,
	output logic [`EXEC_DATA_WIDTH-1:0]		memWriteData,
	input  logic							memAck,
	input  logic [`EXEC_DATA_WIDTH-1:0]		memReadData,
	input  logic							loadQueueFull,
	output logic							loadResultValid,
	output logic [`EXEC_TAG_WIDTH-1:0]		loadResultTag,
	output logic [`EXEC_DATA_WIDTH-1:0]		loadResultData
);

	typedef enum logic [1:0] {
		stateIdle,
		stateRequest,
		stateHold			// Load data waits for queue room
	} lsuState_t;

	lsuState_t						state;
	logic [`EXEC_DATA_WIDTH-1:0]	address;
	logic [`EXEC_TAG_WIDTH-1:0]		requestTag;
	logic [`EXEC_DATA_WIDTH-1:0]	heldData;
	logic							loadAck;

	assign address		= issueSrc1 + issueSrc2;
	assign loadAck		= (state == stateRequest) && memAck && !memWrite;
	assign lsuReady		= (state == stateIdle);
	assign memReq		= (state == stateRequest);

	// Load goes straight to its queue on the ack edge when there is room
	assign loadResultValid	= loadAck || (state == stateHold);
	assign loadResultTag	= requestTag;
	assign loadResultData	= (state == stateHold) ? heldData : memReadData;

	////////////////////
	// Sequencer
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state	<= stateIdle;
		end else begin
			case (state)
				stateIdle: begin
					if (lsuIssue) begin
						state	<= stateRequest;
					end
				end
				stateRequest: begin
					if (memAck) begin
						state	<= (loadAck && loadQueueFull) ? stateHold : stateIdle;
					end
				end
				default: begin
					if (!loadQueueFull) begin
						state	<= stateIdle;
					end
				end
			endcase
		end
	end

	// Request fields stay stable until ack
	always_ff @(posedge clock) begin
		if (lsuIssue && state == stateIdle) begin
			memWrite		<= issueIsStore;
			memAddr			<= address[`EXEC_ADDR_WIDTH-1:0];
			memWriteData	<= issueSrc2;
			requestTag		<= issueTag;
		end
		if (loadAck) begin
			heldData		<= memReadData;
		end
	end

endmodule

// ==== verilog/writeBackMerge.sv ====
////////////////////
// Write-back output side
// Per-path result queues, priority merge, credit counter
////////////////////
`include "execUnit_config.svh"

module writeBackMerge (
	input  logic							clock,
	input  logic							reset,
	input  logic							aluResultValid,
	input  logic [`EXEC_TAG_WIDTH-1:0]		aluResultTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		aluResultData,
	input  logic							moveIssue,
	input  logic [`EXEC_TAG_WIDTH-1:0]		issueTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		issueSrc1,
	input  logic							loadResultValid,
	input  logic [`EXEC_TAG_WIDTH-1:0]		loadResultTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		loadResultData,
	output logic							aluQueueFull,
	output logic							moveReady,
	output logic							loadQueueFull,
	input  logic							wbCredit,
	output logic							wbValid,
	output logic [`EXEC_TAG_WIDTH-1:0]		wbTag,
	output logic [`EXEC_DATA_WIDTH-1:0]		wbData,
	output execPkg::wbSource_t				wbSource
);

	localparam int CREDIT_WIDTH = $clog2(`EXEC_WB_CREDITS + 1);

	execPkg::wbEntry_t			entryIn [3];	// Index by wbSource_t
	execPkg::wbEntry_t			head [3];
	logic [2:0]					push;
	logic [2:0]					pop;
	logic [2:0]					full;
	logic [2:0]					empty;
	logic [CREDIT_WIDTH-1:0]	credits;
	logic						haveCredit;
	execPkg::wbEntry_t			selected;

	assign entryIn[0] = '{tag: aluResultTag, data: aluResultData, source: execPkg::sourceAlu};
	assign entryIn[1] = '{tag: issueTag, data: issueSrc1, source: execPkg::sourceMove};
	assign entryIn[2] = '{tag: loadResultTag, data: loadResultData, source: execPkg::sourceLoad};

	assign push[0]	= aluResultValid && !full[0];
	assign push[1]	= moveIssue;						// Decode checks moveReady
	assign push[2]	= loadResultValid && !full[2];

	assign aluQueueFull		= full[0];
	assign moveReady		= !full[1];
	assign loadQueueFull	= full[2];

	for (genvar i = 0; i < 3; i++) begin : gen_queue
		ringBuffer #(
			.TYPE(execPkg::wbEntry_t),
			.DEPTH(`EXEC_RESULT_DEPTH)
		) resultQueue_i (
			.clock(clock),
			.reset(reset),
			.write(push[i]),
			.read(pop[i]),
			.writeData(entryIn[i]),
			.readData(head[i]),
			.full(full[i]),
			.empty(empty[i]),
			.count()
		);
	end

	////////////////////
	// Merge
	////////////////////
	assign haveCredit = (credits != '0);

	// Load first, then ALU, then move
	always_comb begin
		pop			= '0;
		selected	= head[2];
		if (haveCredit) begin
			if (!empty[2]) begin
				pop[2]		= 1'b1;
			end else if (!empty[0]) begin
				pop[0]		= 1'b1;
				selected	= head[0];
			end else if (!empty[1]) begin
				pop[1]		= 1'b1;
				selected	= head[1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wbValid	<= 1'b0;
			credits	<= CREDIT_WIDTH'(`EXEC_WB_CREDITS);
		end else begin
			wbValid	<= |pop;
			// Spent at selection, returned on wbCredit
			if ((|pop) && !wbCredit) begin
				credits	<= credits - 1'b1;
			end else if (!(|pop) && wbCredit) begin
				credits	<= credits + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (|pop) begin
			wbTag		<= selected.tag;
			wbData		<= selected.data;
			wbSource	<= selected.source;
		end
	end

endmodule

// ==== verilog/execUnit.sv ====
////////////////////
// Scalar execution stage top
////////////////////
`include "execUnit_config.svh"

module execUnit (
	input  logic							clock,
	input  logic							reset,
	input  logic							commandValid,
	input  execPkg::commandKind_t			commandKind,
	input  execPkg::aluOp_t					commandAluOp,
	input  logic [`EXEC_TAG_WIDTH-1:0]		commandTag,
	input  logic [`EXEC_DATA_WIDTH-1:0]		commandSrc1,
	input  logic [`EXEC_DATA_WIDTH-1:0]		commandSrc2,
	output logic							commandCredit,
	output logic							memReq,
	output logic							memWrite,
	output logic [`EXEC_ADDR_WIDTH-1:0]		memAddr,
	output logic [`EXEC_DATA_WIDTH-1:0]		memWriteData,
	input  logic							memAck,
	input  logic [`EXEC_DATA_WIDTH-1:0]		memReadData,
	input  logic							wbCredit,
	output logic							wbValid,
	output logic [`EXEC_TAG_WIDTH-1:0]		wbTag,
	output logic [`EXEC_DATA_WIDTH-1:0]		wbData,
	output execPkg::wbSource_t				wbSource
);

	// Dispatch
	logic							aluIssue;
	logic							moveIssue;
	logic							lsuIssue;
	logic							aluReady;
	logic							moveReady;
	logic							lsuReady;
	execPkg::aluOp_t				issueAluOp;
	logic							issueIsStore;
	logic [`EXEC_TAG_WIDTH-1:0]		issueTag;
	logic [`EXEC_DATA_WIDTH-1:0]	issueSrc1;
	logic [`EXEC_DATA_WIDTH-1:0]	issueSrc2;

	// Results
	logic							aluResultValid;
	logic [`EXEC_TAG_WIDTH-1:0]		aluResultTag;
	logic [`EXEC_DATA_WIDTH-1:0]	aluResultData;
	logic							aluQueueFull;
	logic							loadResultValid;
	logic [`EXEC_TAG_WIDTH-1:0]		loadResultTag;
	logic [`EXEC_DATA_WIDTH-1:0]	loadResultData;
	logic							loadQueueFull;

	commandDecode commandDecode_i (
		.clock(clock),
		.reset(reset),
		.commandValid(commandValid),
		.commandKind(commandKind),
		.commandAluOp(commandAluOp),
		.commandTag(commandTag),
		.commandSrc1(commandSrc1),
		.commandSrc2(commandSrc2),
		.commandCredit(commandCredit),
		.aluReady(aluReady),
		.moveReady(moveReady),
		.lsuReady(lsuReady),
		.aluIssue(aluIssue),
		.moveIssue(moveIssue),
		.lsuIssue(lsuIssue),
		.issueAluOp(issueAluOp),
		.issueIsStore(issueIsStore),
		.issueTag(issueTag),
		.issueSrc1(issueSrc1),
		.issueSrc2(issueSrc2)
	);

	scalarAlu scalarAlu_i (
		.clock(clock),
		.reset(reset),
		.aluIssue(aluIssue),
		.issueAluOp(issueAluOp),
		.issueTag(issueTag),
		.issueSrc1(issueSrc1),
		.issueSrc2(issueSrc2),
		.aluReady(aluReady),
		.aluQueueFull(aluQueueFull),
		.aluResultValid(aluResultValid),
		.aluResultTag(aluResultTag),
		.aluResultData(aluResultData)
	);

	loadStoreUnit loadStoreUnit_i (
		.clock(clock),
		.reset(reset),
		.lsuIssue(lsuIssue),
		.issueIsStore(issueIsStore),
		.issueTag(issueTag),
		.issueSrc1(issueSrc1),
		.issueSrc2(issueSrc2),
		.lsuReady(lsuReady),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData),
		.loadQueueFull(loadQueueFull),
		.loadResultValid(loadResultValid),
		.loadResultTag(loadResultTag),
		.loadResultData(loadResultData)
	);

	writeBackMerge writeBackMerge_i (
		.clock(clock),
		.reset(reset),
		.aluResultValid(aluResultValid),
		.aluResultTag(aluResultTag),
		.aluResultData(aluResultData),
		.moveIssue(moveIssue),
		.issueTag(issueTag),
		.issueSrc1(issueSrc1),
		.loadResultValid(loadResultValid),
		.loadResultTag(loadResultTag),
		.loadResultData(loadResultData),
		.aluQueueFull(aluQueueFull),
		.moveReady(moveReady),
		.loadQueueFull(loadQueueFull),
		.wbCredit(wbCredit),
		.wbValid(wbValid),
		.wbTag(wbTag),
		.wbData(wbData),
		.wbSource(wbSource)
	);

endmodule

// ==== testbench/execModel.svh ====
////////////////////
// Execution stage reference model
// Memory image, expected results and write-back scoreboard
////////////////////
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

localparam int TAG_COUNT = 1 << `EXEC_TAG_WIDTH;
localparam int MEM_WORDS = 1 << `EXEC_ADDR_WIDTH;

logic [`EXEC_DATA_WIDTH-1:0]	modelMem [MEM_WORDS];		// Stores applied in command order
logic [`EXEC_DATA_WIDTH-1:0]	deviceMem [MEM_WORDS];		// Written by DUT store requests
logic [`EXEC_DATA_WIDTH-1:0]	expectedData [TAG_COUNT];
execPkg::wbSource_t				expectedSource [TAG_COUNT];
logic							tagBusy [TAG_COUNT];
int								busyCount;
logic [`EXEC_TAG_WIDTH-1:0]		aluOrder [$];				// Issue order per source
logic [`EXEC_TAG_WIDTH-1:0]		moveOrder [$];
logic [`EXEC_TAG_WIDTH-1:0]		loadOrder [$];
logic [`EXEC_ADDR_WIDTH-1:0]	storeAddrQ [$];
logic [`EXEC_DATA_WIDTH-1:0]	storeDataQ [$];
int								errorCount;
int								checkCount;

// Pattern differs for every word address
function automatic logic [`EXEC_DATA_WIDTH-1:0] fillWord(input int addr);
	logic [7:0]	a;
	a = 8'(addr);
	return {a ^ 8'h5a, ~a, a + 8'h33, a};
endfunction

function automatic logic [`EXEC_DATA_WIDTH-1:0] aluModel(input execPkg::aluOp_t op,
		input logic [`EXEC_DATA_WIDTH-1:0] a, input logic [`EXEC_DATA_WIDTH-1:0] b);
	case (op)
		execPkg::opAdd:	return a + b;
		execPkg::opSub:	return a - b;
		execPkg::opAnd:	return a & b;
		execPkg::opOr:	return a | b;
		execPkg::opXor:	return a ^ b;
		execPkg::opShl:	return a << b[4:0];
		execPkg::opShr:	return a >> b[4:0];
		default:		return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;	// Signed compare
	endcase
endfunction

task automatic expectResult(input logic [`EXEC_TAG_WIDTH-1:0] tag,
		input logic [`EXEC_DATA_WIDTH-1:0] data, input execPkg::wbSource_t source);
	expectedData[tag]	= data;
	expectedSource[tag]	= source;
	tagBusy[tag]		= 1'b1;
	busyCount++;
	case (source)
		execPkg::sourceAlu:		aluOrder.push_back(tag);
		execPkg::sourceMove:	moveOrder.push_back(tag);
		default:				loadOrder.push_back(tag);
	endcase
endtask

////////////////////
// Scoreboard
////////////////////
task automatic checkWriteBack(input logic [`EXEC_TAG_WIDTH-1:0] tag,
		input logic [`EXEC_DATA_WIDTH-1:0] data, input execPkg::wbSource_t source);
	logic [`EXEC_TAG_WIDTH-1:0]	oldest;
	checkCount++;
	assert (tagBusy[tag]) else begin
		$display("Write-back at %0t carries tag %0d, which has no result outstanding",
			$time, tag);
		errorCount++;
	end
	if (tagBusy[tag]) begin
		case (expectedSource[tag])
			execPkg::sourceAlu:		oldest = aluOrder.pop_front();
			execPkg::sourceMove:	oldest = moveOrder.pop_front();
			default:				oldest = loadOrder.pop_front();
		endcase
		assert (tag == oldest) else begin
			$display("Mismatch at %0t: tag %0d out of order, expected %0d", $time, tag, oldest);
			errorCount++;
		end
		assert (source == expectedSource[tag]) else begin
			$display("Mismatch at %0t: tag %0d source %0d, expected %0d", $time, tag,
				source, expectedSource[tag]);
			errorCount++;
		end
		assert (data == expectedData[tag]) else begin
			$display("Mismatch at %0t: tag %0d data %h, expected %h", $time, tag, data,
				expectedData[tag]);
			errorCount++;
		end
		tagBusy[tag]	= 1'b0;
		busyCount--;
	end
endtask

task automatic checkStore(input logic [`EXEC_ADDR_WIDTH-1:0] addr,
		input logic [`EXEC_DATA_WIDTH-1:0] data);
	logic [`EXEC_ADDR_WIDTH-1:0]	wantAddr;
	logic [`EXEC_DATA_WIDTH-1:0]	wantData;
	checkCount++;
	assert (storeAddrQ.size() > 0) else begin
		$display("Store request at %0t while no store was outstanding", $time);
		errorCount++;
	end
	if (storeAddrQ.size() > 0) begin
		wantAddr = storeAddrQ.pop_front();
		wantData = storeDataQ.pop_front();
		assert (addr == wantAddr && data == wantData) else begin
			$display("Mismatch at %0t: store to %h data %h, expected %h data %h", $time,
				addr, data, wantAddr, wantData);
			errorCount++;
		end
	end
endtask

`endif

// ==== testbench/execUnitTb.sv ====
////////////////////
// Execution stage testbench
// Random command streams checked against the reference model
////////////////////
`include "execUnit_config.svh"

module execUnitTb;

	localparam int ALU_COUNT		= 200;
	localparam int MOVE_COUNT		= 60;
	localparam int MEM_COUNT		= 80;
	localparam int MIXED_COUNT		= 100;
	localparam int HOLD_COUNT		= 30;
	localparam int TOTAL_COMMANDS	= ALU_COUNT + MOVE_COUNT + MEM_COUNT + MIXED_COUNT + HOLD_COUNT;
	localparam int CYCLE_LIMIT		= 40 * TOTAL_COMMANDS;

	logic							clock;
	logic							reset;
	logic							commandValid;
	execPkg::commandKind_t			commandKind;
	execPkg::aluOp_t				commandAluOp;
	logic [`EXEC_TAG_WIDTH-1:0]		commandTag;
	logic [`EXEC_DATA_WIDTH-1:0]	commandSrc1;
	logic [`EXEC_DATA_WIDTH-1:0]	commandSrc2;
	logic							commandCredit;
	logic							memReq;
	logic							memWrite;
	logic [`EXEC_ADDR_WIDTH-1:0]	memAddr;
	logic [`EXEC_DATA_WIDTH-1:0]	memWriteData;
	logic							memAck;
	logic [`EXEC_DATA_WIDTH-1:0]	memReadData;
	logic							wbCredit;
	logic							wbValid;
	logic [`EXEC_TAG_WIDTH-1:0]		wbTag;
	logic [`EXEC_DATA_WIDTH-1:0]	wbData;
	execPkg::wbSource_t				wbSource;

	`include "execModel.svh"

	execPkg::command_t				pending [$];		// Generated, not yet sent
	execPkg::command_t				sendNow;
	logic [`EXEC_TAG_WIDTH-1:0]		nextTag;
	int								senderCredits;
	int								commandsSent;
	int								creditsReturned;
	int								wbGranted;			// Model of the DUT write-back credit
	int								wbSeen;
	int								wbReturned;
	logic							holdWbCredit;
	int								windowCount;
	int								cycleCount;
	int								postResetCycles;
	logic							memBusy;
	int								memDelay;
	int								testsRun;
	int								testsFailed;
	int								errorBase;
	int								checkBase;
	int								sentBase;
	int								returnedBase;

	execUnit execUnit_i (
		.clock(clock),
		.reset(reset),
		.commandValid(commandValid),
		.commandKind(commandKind),
		.commandAluOp(commandAluOp),
		.commandTag(commandTag),
		.commandSrc1(commandSrc1),
		.commandSrc2(commandSrc2),
		.commandCredit(commandCredit),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData),
		.wbCredit(wbCredit),
		.wbValid(wbValid),
		.wbTag(wbTag),
		.wbData(wbData),
		.wbSource(wbSource)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////
	// Stimulus generation
	////////////////////
	task automatic queueCommand(input execPkg::commandKind_t kind, input execPkg::aluOp_t op,
			input logic [`EXEC_DATA_WIDTH-1:0] src1, input logic [`EXEC_DATA_WIDTH-1:0] src2);
		logic [`EXEC_ADDR_WIDTH-1:0]	addr;
		execPkg::command_t				entry;
		while (busyCount >= 40) @(posedge clock);		// Keeps tags unique
		while (tagBusy[nextTag]) nextTag++;
		addr = `EXEC_ADDR_WIDTH'(src1 + src2);
		case (kind)
			execPkg::kindAlu:	expectResult(nextTag, aluModel(op, src1, src2), execPkg::sourceAlu);
			execPkg::kindMove:	expectResult(nextTag, src1, execPkg::sourceMove);
			execPkg::kindLoad:	expectResult(nextTag, modelMem[addr], execPkg::sourceLoad);
			default: begin
				modelMem[addr] = src2;
				storeAddrQ.push_back(addr);
				storeDataQ.push_back(src2);
			end
		endcase
		entry.kind	= kind;
		entry.aluOp	= op;
		entry.tag	= nextTag;
		entry.src1	= src1;
		entry.src2	= src2;
		pending.push_back(entry);
		nextTag++;
	endtask

	task automatic queueAlu();
		queueCommand(execPkg::kindAlu, execPkg::aluOp_t'($urandom_range(0, 7)), $urandom, $urandom);
	endtask

	task automatic queueMove();
		queueCommand(execPkg::kindMove, execPkg::opAdd, $urandom, $urandom);
	endtask

	// Address lands in a 16-word window at 0x40
	task automatic queueMemory(input logic isStore);
		logic [7:0]						target;
		logic [`EXEC_DATA_WIDTH-1:0]	src1;
		logic [`EXEC_DATA_WIDTH-1:0]	src2;
		target		= 8'h40 + 8'($urandom_range(0, 15));
		src2		= $urandom;
		src1		= $urandom;
		src1[7:0]	= target - src2[7:0];
		queueCommand(isStore ? execPkg::kindStore : execPkg::kindLoad, execPkg::opAdd, src1, src2);
	endtask

	task automatic queueMixed();
		case ($urandom_range(0, 3))
			0:			queueAlu();
			1:			queueMove();
			default:	queueMemory($urandom_range(0, 1) == 1);
		endcase
	endtask

	// Everything sent and answered
	task automatic waitDrain();
		while (pending.size() > 0 || busyCount > 0 || storeAddrQ.size() > 0) begin
			@(posedge clock);
		end
	endtask

	task automatic startTest();
		errorBase = errorCount;
		checkBase = checkCount;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errorCount != errorBase) begin
			testsFailed++;
		end
		$display("Test %s done: %0d checks, %0d errors", name, checkCount - checkBase,
			errorCount - errorBase);
	endtask

	////////////////////
	// Drive inputs and sample outputs on the falling edge
	////////////////////
	always @(negedge clock) begin
		cycleCount++;
		if (reset || postResetCycles < 3) begin
			checkCount++;
			assert (!wbValid && !memReq && !commandCredit) else begin
				$display("Mismatch at %0t: around reset wbValid %b memReq %b commandCredit %b",
					$time, wbValid, memReq, commandCredit);
				errorCount++;
			end
			if (!reset) begin
				postResetCycles++;
			end
		end
		if (cycleCount == 4) begin
			reset = 1'b0;					// After four rising edges
		end

		if (commandCredit) begin
			senderCredits++;
			creditsReturned++;
			assert (senderCredits <= `EXEC_COMMAND_DEPTH) else begin
				$display("More command credits came back at %0t than were spent", $time);
				errorCount++;
			end
		end

		if (wbValid) begin
			assert (wbGranted > 0) else begin
				$display("Write-back at %0t was issued with no credit left", $time);
				errorCount++;
			end
			wbGranted--;
			wbSeen++;
			windowCount++;
			checkWriteBack(wbTag, wbData, wbSource);
		end
		wbCredit = 1'b0;
		if (!holdWbCredit && wbSeen > wbReturned && $urandom_range(0, 1) == 1) begin
			wbCredit = 1'b1;
			wbReturned++;
			wbGranted++;
		end

		// Memory with a random ack delay
		if (memAck) begin
			memAck = 1'b0;
		end else if (memReq) begin
			if (!memBusy) begin
				memBusy		= 1'b1;
				memDelay	= $urandom_range(1, 5);
			end
			memDelay--;
			if (memDelay == 0) begin
				memAck	= 1'b1;
				memBusy	= 1'b0;
				if (memWrite) begin
					checkStore(memAddr, memWriteData);
					deviceMem[memAddr] = memWriteData;
				end else begin
					memReadData = deviceMem[memAddr];
				end
			end
		end

		commandValid = 1'b0;
		if (!reset && pending.size() > 0 && senderCredits > 0) begin
			sendNow			= pending.pop_front();
			commandValid	= 1'b1;
			commandKind		= sendNow.kind;
			commandAluOp	= sendNow.aluOp;
			commandTag		= sendNow.tag;
			commandSrc1		= sendNow.src1;
			commandSrc2		= sendNow.src2;
			senderCredits--;
			commandsSent++;
		end

		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d results still outstanding",
				cycleCount, busyCount);
			$display("sim failed");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		void'($urandom(32'hee17_fdaa));
		reset			= 1'b1;
		commandValid	= 1'b0;
		commandKind		= execPkg::kindAlu;
		commandAluOp	= execPkg::opAdd;
		commandTag		= '0;
		commandSrc1		= '0;
		commandSrc2		= '0;
		memAck			= 1'b0;
		memReadData		= '0;
		wbCredit		= 1'b0;
		holdWbCredit	= 1'b0;
		memBusy			= 1'b0;
		nextTag			= '0;
		senderCredits	= `EXEC_COMMAND_DEPTH;
		wbGranted		= `EXEC_WB_CREDITS;
		for (int i = 0; i < MEM_WORDS; i++) begin
			modelMem[i]		= fillWord(i);
			deviceMem[i]	= fillWord(i);
		end
		for (int i = 0; i < TAG_COUNT; i++) begin
			tagBusy[i] = 1'b0;
		end

		startTest();
		while (postResetCycles < 3) @(posedge clock);
		finishTest("reset");

		startTest();
		repeat (ALU_COUNT) queueAlu();
		waitDrain();
		finishTest("alu");

		startTest();
		repeat (MOVE_COUNT) queueMove();
		waitDrain();
		finishTest("move");

		startTest();
		repeat (MEM_COUNT) queueMemory($urandom_range(0, 1) == 1);
		waitDrain();
		finishTest("memory");

		startTest();
		sentBase		= commandsSent;
		returnedBase	= creditsReturned;
		repeat (MIXED_COUNT) queueMixed();
		waitDrain();
		checkCount++;
		assert (creditsReturned - returnedBase == commandsSent - sentBase) else begin
			$display("Mismatch at %0t: %0d commands sent, %0d credits returned", $time,
				commandsSent - sentBase, creditsReturned - returnedBase);
			errorCount++;
		end
		finishTest("input credit");

		// Write-back credit withheld for 50 cycles
		startTest();
		holdWbCredit	= 1'b1;
		windowCount		= 0;
		repeat (HOLD_COUNT) queueMixed();
		repeat (50) @(posedge clock);
		checkCount++;
		assert (windowCount <= `EXEC_WB_CREDITS) else begin
			$display("Mismatch at %0t: %0d write-backs while credit was held, limit %0d",
				$time, windowCount, `EXEC_WB_CREDITS);
			errorCount++;
		end
		holdWbCredit = 1'b0;
		waitDrain();
		finishTest("back-pressure");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+testbench
verilog/execPkg.sv
verilog/ringBuffer.sv
verilog/commandDecode.sv
verilog/scalarAlu.sv
verilog/loadStoreUnit.sv
verilog/writeBackMerge.sv
verilog/execUnit.sv
testbench/execUnitTb.sv

// ==== Makefile ====
# Verilator build and run of the execution stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module execUnitTb -Mdir obj_dir -o execUnitTb
	./obj_dir/execUnitTb | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
